// ==== cu_core_pkg.sv ====
`default_nettype none

package cu_core_pkg;

    // Datapath and address width
    localparam int xlen = 32;

    // Scalar register count
    localparam int nregs = 32;

    typedef logic [$clog2(nregs)-1:0] reg_idx_t;
    typedef logic [xlen-1:0]          word_t;

    // Wishbone classic master request
    // Word access only, so there are no byte selects
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat_w;
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== cu_isa_pkg.sv ====
`default_nettype none

package cu_isa_pkg;

    // Major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 for arithmetic
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct3 for branches and memory width
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_word = 3'b010;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        cu_core_pkg::reg_idx_t rs2;
        cu_core_pkg::reg_idx_t rs1;
        logic [2:0]            funct3;
        cu_core_pkg::reg_idx_t rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        cu_core_pkg::reg_idx_t rs2;
        cu_core_pkg::reg_idx_t rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // R view also carries I-type, since its top twelve bits are the immediate
    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } instr_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  uses_rs1;
        logic                  uses_rs2;
        logic                  writes_rd;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic [2:0]            br_cond;
        cu_core_pkg::reg_idx_t rs1;
        cu_core_pkg::reg_idx_t rs2;
        cu_core_pkg::reg_idx_t rd;
        cu_core_pkg::word_t    imm;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== cu_fetch.sv ====
`default_nettype none

module cu_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               redirect,
    input  cu_core_pkg::word_t target,
    output cu_core_pkg::word_t pc
);
    import cu_core_pkg::*;

    word_t pc_next;

    // A taken branch in EX overrides a hazard hold on the front end
    always_comb begin
        if (redirect) begin
            pc_next = target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + word_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== cu_decoder.sv ====
`default_nettype none

module cu_decoder (
    input  cu_isa_pkg::instr_u instr,
    output cu_isa_pkg::ctrl_t  ctrl
);
    import cu_core_pkg::*;
    import cu_isa_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;

    // Register and immediate forms share the funct3 encoding
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic is_sub);
        case (funct3)
            f3_add:  return is_sub ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_xor:  return alu_xor;
            f3_srl:  return alu_srl;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign imm_i = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    // B immediate is scattered across both halves of the S fields
    assign imm_b = {{19{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                    instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};

    always_comb begin
        ctrl = '0;
        case (instr.r.opcode)
            op_reg: begin
                ctrl = '{valid: 1'b1, uses_rs1: 1'b1, uses_rs2: 1'b1, writes_rd: 1'b1,
                         alu_op: arith_op(instr.r.funct3, instr.r.funct7 == f7_sub),
                         rs1: instr.r.rs1, rs2: instr.r.rs2, rd: instr.r.rd, default: '0};
            end
            op_imm: begin
                ctrl = '{valid: 1'b1, use_imm: 1'b1, uses_rs1: 1'b1, writes_rd: 1'b1,
                         alu_op: arith_op(instr.r.funct3, 1'b0),
                         rs1: instr.r.rs1, rd: instr.r.rd, imm: imm_i, default: '0};
            end
            op_load: begin
                ctrl = '{valid: instr.r.funct3 == f3_word, use_imm: 1'b1, uses_rs1: 1'b1,
                         writes_rd: instr.r.funct3 == f3_word, is_load: 1'b1,
                         alu_op: alu_add, rs1: instr.r.rs1, rd: instr.r.rd, imm: imm_i,
                         default: '0};
            end
            op_store: begin
                ctrl = '{valid: instr.s.funct3 == f3_word, uses_rs1: 1'b1, uses_rs2: 1'b1,
                         is_store: 1'b1, alu_op: alu_add, rs1: instr.s.rs1,
                         rs2: instr.s.rs2, imm: imm_s, default: '0};
            end
            op_branch: begin
                ctrl = '{valid: 1'b1, uses_rs1: 1'b1, uses_rs2: 1'b1, is_branch: 1'b1,
                         br_cond: instr.s.funct3, alu_op: alu_sub, rs1: instr.s.rs1,
                         rs2: instr.s.rs2, imm: imm_b, default: '0};
            end
            // Anything else falls through as a no-op
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== cu_scoreboard.sv ====
`default_nettype none

module cu_scoreboard (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  cu_isa_pkg::ctrl_t     id_ctrl,
    input  logic                  wb_we,
    input  cu_core_pkg::reg_idx_t wb_rd,
    output logic                  hazard
);
    import cu_core_pkg::*;

    logic [nregs-1:0] busy;
    logic [nregs-1:0] live;
    logic [nregs-1:0] set_mask;
    logic [nregs-1:0] clear_mask;

    always_comb begin
        clear_mask = '0;
        set_mask   = '0;
        if (wb_we) begin
            clear_mask[wb_rd] = 1'b1;
        end
        // x0 never becomes busy
        if (issue && id_ctrl.writes_rd && id_ctrl.rd != '0) begin
            set_mask[id_ctrl.rd] = 1'b1;
        end
    end

    // Retiring register is readable this cycle through the regfile bypass
    assign live = busy & ~clear_mask;

    // Destination is checked too so an older write cannot clear a younger busy bit
    assign hazard = id_ctrl.valid &&
                    ((id_ctrl.uses_rs1  && live[id_ctrl.rs1]) ||
                     (id_ctrl.uses_rs2  && live[id_ctrl.rs2]) ||
                     (id_ctrl.writes_rd && live[id_ctrl.rd]));

    // Set wins over clear for the same register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= live | set_mask;
        end
    end

endmodule

`default_nettype wire

// ==== cu_regfile.sv ====
`default_nettype none

module cu_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cu_core_pkg::reg_idx_t raddr_a,
    input  cu_core_pkg::reg_idx_t raddr_b,
    output cu_core_pkg::word_t    rdata_a,
    output cu_core_pkg::word_t    rdata_b,
    input  logic                  we,
    input  cu_core_pkg::reg_idx_t waddr,
    input  cu_core_pkg::word_t    wdata
);
    import cu_core_pkg::*;

    word_t regs [nregs];

    // Same-cycle write is forwarded to the readers
    function automatic word_t read_port(input reg_idx_t ra, input word_t stored);
        if (ra == '0) begin
            return '0;
        end
        if (we && waddr == ra) begin
            return wdata;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata_a = read_port(raddr_a, regs[raddr_a]);
        rdata_b = read_port(raddr_b, regs[raddr_b]);
    end

endmodule

`default_nettype wire

// ==== cu_alu.sv ====
`default_nettype none

module cu_alu (
    input  cu_isa_pkg::ctrl_t  ctrl,
    input  cu_core_pkg::word_t op_a,
    input  cu_core_pkg::word_t op_b,
    input  cu_core_pkg::word_t pc,
    output cu_core_pkg::word_t result,
    output cu_core_pkg::word_t addr,
    output logic               branch_taken,
    output cu_core_pkg::word_t branch_target
);
    import cu_core_pkg::*;
    import cu_isa_pkg::*;

    word_t      op_b_sel;
    logic [4:0] shamt;
    logic       cond;

    assign op_b_sel = ctrl.use_imm ? ctrl.imm : op_b;
    assign shamt    = op_b_sel[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add: result = op_a + op_b_sel;
            alu_sub: result = op_a - op_b_sel;
            alu_and: result = op_a & op_b_sel;
            alu_or:  result = op_a | op_b_sel;
            alu_xor: result = op_a ^ op_b_sel;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b_sel)};
            alu_sll: result = op_a << shamt;
            alu_srl: result = op_a >> shamt;
            default: result = op_a + op_b_sel;
        endcase
    end

    // Compare the two register operands, never the immediate
    always_comb begin
        case (ctrl.br_cond)
            f3_beq:  cond = (op_a == op_b);
            f3_bne:  cond = (op_a != op_b);
            f3_blt:  cond = ($signed(op_a) < $signed(op_b));
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken  = ctrl.valid && ctrl.is_branch && cond;
    assign branch_target = pc + ctrl.imm;

    // Effective address for lw and sw
    assign addr = op_a + ctrl.imm;

endmodule

`default_nettype wire

// ==== cu_lsu.sv ====
`default_nettype none

module cu_lsu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cu_isa_pkg::ctrl_t    mem_ctrl,
    input  cu_core_pkg::word_t   addr,
    input  cu_core_pkg::word_t   store_data,
    output cu_core_pkg::wb_req_t wb_req,
    input  cu_core_pkg::wb_rsp_t wb_rsp,
    output logic                 stall,
    output cu_core_pkg::word_t   load_data
);
    import cu_core_pkg::*;

    logic mem_op;
    logic ack_last;

    assign mem_op = mem_ctrl.valid && (mem_ctrl.is_load || mem_ctrl.is_store);

    // Bus sits idle for one cycle after every ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_last <= 1'b0;
        end else begin
            ack_last <= wb_req.cyc && wb_rsp.ack;
        end
    end

    // Request comes straight from EX/MEM, which is frozen until ack
    always_comb begin
        wb_req.cyc   = mem_op && !ack_last;
        wb_req.stb   = mem_op && !ack_last;
        wb_req.we    = mem_ctrl.is_store;
        wb_req.adr   = {addr[xlen-1:2], 2'b00};
        wb_req.dat_w = store_data;
    end

    // Released in the ack cycle so MEM/WB captures dat_r at that edge
    assign stall     = mem_op && !(wb_req.cyc && wb_rsp.ack);
    assign load_data = wb_rsp.dat_r;

endmodule

`default_nettype wire

// ==== cu_top.sv ====
`default_nettype none

module cu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    output cu_core_pkg::word_t   inst_addr,
    input  cu_core_pkg::word_t   inst_rdata,
    output cu_core_pkg::wb_req_t wb_req,
    input  cu_core_pkg::wb_rsp_t wb_rsp
);
    import cu_core_pkg::*;
    import cu_isa_pkg::*;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t op_a;
        word_t op_b;
    } id_ex_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
        word_t addr;
        word_t store_data;
    } ex_mem_t;

    // Writeback bundle, shared by regfile and scoreboard
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } mem_wb_t;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    ctrl_t   dec_ctrl;
    ctrl_t   id_ctrl;
    word_t   rf_a;
    word_t   rf_b;
    word_t   ex_result;
    word_t   ex_addr;
    word_t   ex_target;
    word_t   load_data;
    logic    stall_mem;
    logic    stall_hazard;
    logic    ex_taken;
    logic    redirect;
    logic    issue;

    // A branch frozen behind a memory stall must not redirect yet
    assign redirect = ex_taken && !stall_mem;
    assign issue    = id_ctrl.valid && !stall_mem && !stall_hazard && !redirect;

    cu_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall_mem || stall_hazard),
        .redirect(redirect), .target(ex_target), .pc(inst_addr)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (redirect) begin
            if_id.valid <= 1'b0;
        end else if (!(stall_mem || stall_hazard)) begin
            if_id <= '{valid: 1'b1, pc: inst_addr, instr: inst_rdata};
        end
    end

    cu_decoder u_decoder (.instr(if_id.instr), .ctrl(dec_ctrl));

    always_comb begin
        id_ctrl       = dec_ctrl;
        id_ctrl.valid = dec_ctrl.valid && if_id.valid;
    end

    cu_scoreboard u_scoreboard (
        .clk(clk), .rst_n(rst_n), .issue(issue), .id_ctrl(id_ctrl),
        .wb_we(mem_wb.we), .wb_rd(mem_wb.rd), .hazard(stall_hazard)
    );

    cu_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .raddr_a(id_ctrl.rs1), .raddr_b(id_ctrl.rs2),
        .rdata_a(rf_a), .rdata_b(rf_b),
        .we(mem_wb.we), .waddr(mem_wb.rd), .wdata(mem_wb.data)
    );

    // Hazard or flush leaves a bubble in EX
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall_mem) begin
            id_ex            <= '{ctrl: id_ctrl, pc: if_id.pc, op_a: rf_a, op_b: rf_b};
            id_ex.ctrl.valid <= issue;
        end
    end

    cu_alu u_alu (
        .ctrl(id_ex.ctrl), .op_a(id_ex.op_a), .op_b(id_ex.op_b), .pc(id_ex.pc),
        .result(ex_result), .addr(ex_addr),
        .branch_taken(ex_taken), .branch_target(ex_target)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!stall_mem) begin
            ex_mem <= '{ctrl: id_ex.ctrl, result: ex_result, addr: ex_addr,
                        store_data: id_ex.op_b};
        end
    end

    cu_lsu u_lsu (
        .clk(clk), .rst_n(rst_n), .mem_ctrl(ex_mem.ctrl), .addr(ex_mem.addr),
        .store_data(ex_mem.store_data), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .stall(stall_mem), .load_data(load_data)
    );

    // WB retires even while MEM waits, so only a bubble follows it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (stall_mem) begin
            mem_wb.we <= 1'b0;
        end else begin
            mem_wb.we   <= ex_mem.ctrl.valid && ex_mem.ctrl.writes_rd;
            mem_wb.rd   <= ex_mem.ctrl.rd;
            mem_wb.data <= ex_mem.ctrl.is_load ? load_data : ex_mem.result;
        end
    end

endmodule

`default_nettype wire

// ==== cu_properties.sv ====
`default_nettype none

module cu_properties (
    input logic                 clk,
    input logic                 rst_n,
    input cu_core_pkg::word_t   inst_addr,
    input cu_core_pkg::wb_req_t wb_req,
    input cu_core_pkg::wb_rsp_t wb_rsp
);

    // Strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc)
        else $error("wb stb high while cyc is low");

    // Request frozen until the slave acknowledges
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req))
        else $error("wb request changed before ack");

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_req.cyc)
        else $error("wb cyc high right after reset release");

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

bind cu_top cu_properties u_properties (.*);

`default_nettype wire

// ==== tb_cu.sv ====
`default_nettype none

module tb_cu;
    import cu_core_pkg::*;
    import cu_isa_pkg::*;

    localparam word_t marker_adr = 32'h0000_03fc;

    logic    clk;
    logic    rst_n;
    word_t   inst_addr;
    word_t   inst_rdata;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    word_t rom [64];
    word_t dmem [256];
    word_t store_adr [$];
    word_t store_dat [$];
    word_t exp_adr [$];
    word_t exp_dat [$];
    int    store_base = 0;
    int    pc_words = 0;
    int    mismatches = 0;
    int    timeouts = 0;
    string test_name = "";

    // Register op order, entry 1 is sub
    logic [2:0] reg_f3 [8] = '{f3_add, f3_add, f3_and, f3_or, f3_xor, f3_slt, f3_sll, f3_srl};

    cu_top dut (
        .clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    // Combinational instruction ROM
    assign inst_rdata = rom[inst_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic word_t asm_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic word_t asm_i(input logic [6:0] op, input logic [2:0] f3,
                                    input int rd, input int rs1, input int imm);
        word_t iw;
        iw = word_t'(imm);
        return {iw[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t asm_s(input int rs2, input int rs1, input int imm);
        word_t iw;
        iw = word_t'(imm);
        return {iw[11:5], rs2[4:0], rs1[4:0], f3_word, iw[4:0], op_store};
    endfunction

    function automatic word_t asm_b(input logic [2:0] f3, input int rs1, input int rs2,
                                    input int imm);
        word_t iw;
        iw = word_t'(imm);
        return {iw[12], iw[10:5], rs2[4:0], rs1[4:0], f3, iw[4:1], iw[11], op_branch};
    endfunction

    // Expected results straight from the ISA rules
    function automatic word_t ref_alu(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
        case (f3)
            f3_add:  return sub ? a - b : a + b;
            f3_sll:  return a << b[4:0];
            f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_xor:  return a ^ b;
            f3_srl:  return a >> b[4:0];
            f3_or:   return a | b;
            f3_and:  return a & b;
            default: return '0;
        endcase
    endfunction

    // Wishbone slave with 0 to 3 wait states per transfer
    initial begin : data_memory_model
        word_t rng;
        int    wait_left;
        rng       = 32'hd01c8230;
        wait_left = -1;
        wb_rsp    = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n || wb_rsp.ack) begin
                wb_rsp    = '0;
                wait_left = -1;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wait_left < 0) begin
                    rng       = xorshift32(rng);
                    wait_left = int'(rng % 32'd4);
                end
                if (wait_left == 0) begin
                    wb_rsp.ack   = 1'b1;
                    wb_rsp.dat_r = dmem[wb_req.adr[9:2]];
                    if (wb_req.we) begin
                        store_adr.push_back(wb_req.adr);
                        store_dat.push_back(wb_req.dat_w);
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic emit(input word_t w);
        rom[pc_words[5:0]] = w;
        pc_words++;
    endtask

    task automatic expect_store(input word_t adr, input word_t dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    // Holds the core in reset and loads halt loops and the memory pattern
    task automatic begin_test(input string name);
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        test_name = name;
        pc_words  = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = asm_b(f3_beq, 0, 0, 0);
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(word_t'(i) << 2);
        end
        exp_adr.delete();
        exp_dat.delete();
        $display("Running test: %s", name);
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        #1;
        store_base = store_adr.size();
        rst_n      = 1'b1;
    endtask

    // Every program ends with a store to the marker address
    task automatic finish_program();
        emit(asm_s(0, 0, int'(marker_adr)));
        expect_store(marker_adr, '0);
    endtask

    task automatic wait_for_marker();
        bit found;
        found = 1'b0;
        for (int c = 0; c < 2000 && !found; c++) begin
            @(negedge clk);
            for (int i = store_base; i < store_adr.size(); i++) begin
                if (store_adr[i] == marker_adr) begin
                    found = 1'b1;
                end
            end
        end
        if (!found) begin
            timeouts++;
            $display("Timeout: test %s never reached its final store", test_name);
        end
    endtask

    task automatic compare_stores();
        int n_got;
        n_got = store_adr.size() - store_base;
        check_value("store count", word_t'(n_got), word_t'(exp_adr.size()));
        for (int i = 0; i < exp_adr.size() && i < n_got; i++) begin
            check_value($sformatf("wb_req.adr of store %0d", i),
                        store_adr[store_base + i], exp_adr[i]);
            check_value($sformatf("wb_req.dat_w of store %0d", i),
                        store_dat[store_base + i], exp_dat[i]);
        end
    endtask

    task automatic run_and_check();
        release_reset();
        wait_for_marker();
        compare_stores();
    endtask

    task automatic test_reset_state();
        begin_test("reset state");
        for (int i = 0; i < 64; i++) begin
            rom[i] = asm_i(op_imm, f3_add, 0, 0, 0);
        end
        @(negedge clk);
        check_value("wb_req.cyc in reset", word_t'(wb_req.cyc), '0);
        check_value("inst_addr in reset", inst_addr, '0);
        release_reset();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value("inst_addr", inst_addr, word_t'(4 * i));
            check_value("wb_req.cyc", word_t'(wb_req.cyc), '0);
        end
    endtask

    task automatic test_alu_ops();
        word_t a;
        word_t b;
        word_t imm;
        word_t res [15];
        int    k;
        begin_test("alu operations");
        a = word_t'(-7);
        b = 32'd3;
        emit(asm_i(op_imm, f3_add, 1, 0, -7));
        emit(asm_i(op_imm, f3_add, 2, 0, 3));
        for (int i = 0; i < 8; i++) begin
            emit(asm_r(i == 1 ? f7_sub : 7'd0, reg_f3[i], 3 + i, 1, 2));
            res[i] = ref_alu(reg_f3[i], i == 1, a, b);
        end
        // Immediate forms, shifts by 5 and the rest against -3
        k = 8;
        for (int i = 0; i < 8; i++) begin
            if (i != 1) begin
                imm = (reg_f3[i] == f3_sll || reg_f3[i] == f3_srl) ? 32'd5 : word_t'(-3);
                emit(asm_i(op_imm, reg_f3[i], 3 + k, 1, int'(imm)));
                res[k] = ref_alu(reg_f3[i], 1'b0, a, imm);
                k++;
            end
        end
        for (int j = 0; j < 15; j++) begin
            emit(asm_s(3 + j, 0, 'h100 + 4 * j));
            expect_store(word_t'('h100 + 4 * j), res[j]);
        end
        finish_program();
        run_and_check();
    endtask

    task automatic test_load_use();
        begin_test("load use");
        emit(asm_i(op_imm, f3_add, 1, 0, 'h200));
        emit(asm_i(op_load, f3_word, 2, 1, 0));
        emit(asm_r(7'd0, f3_add, 3, 2, 1));
        emit(asm_s(3, 0, 'h300));
        emit(asm_i(op_load, f3_word, 4, 1, 4));
        emit(asm_i(op_imm, f3_add, 5, 4, -1));
        emit(asm_r(7'd0, f3_add, 6, 5, 5));
        emit(asm_s(6, 0, 'h304));
        expect_store(32'h300, fill_word(32'h200) + 32'h200);
        expect_store(32'h304, (fill_word(32'h204) - 32'd1) * 32'd2);
        finish_program();
        run_and_check();
    endtask

    task automatic test_branches();
        begin_test("branches");
        emit(asm_i(op_imm, f3_add, 1, 0, 5));
        emit(asm_i(op_imm, f3_add, 2, 0, -3));
        // Taken, each skips the store right behind it
        emit(asm_b(f3_beq, 1, 1, 8));
        emit(asm_s(1, 0, 'h310));
        emit(asm_b(f3_bne, 1, 2, 8));
        emit(asm_s(1, 0, 'h314));
        emit(asm_b(f3_blt, 2, 1, 8));
        emit(asm_s(1, 0, 'h318));
        // Not taken, blt here would be taken if compared unsigned
        emit(asm_b(f3_beq, 1, 2, 8));
        emit(asm_s(1, 0, 'h320));
        emit(asm_b(f3_bne, 1, 1, 8));
        emit(asm_s(2, 0, 'h324));
        emit(asm_b(f3_blt, 1, 2, 8));
        emit(asm_s(2, 0, 'h328));
        expect_store(32'h320, 32'd5);
        expect_store(32'h324, word_t'(-3));
        expect_store(32'h328, word_t'(-3));
        finish_program();
        run_and_check();
    endtask

    task automatic test_back_pressure();
        begin_test("back pressure");
        for (int r = 1; r <= 10; r++) begin
            emit(asm_i(op_imm, f3_add, r, 0, 37 * r - 100));
        end
        for (int r = 1; r <= 10; r++) begin
            emit(asm_s(r, 0, 'h340 + 4 * (r - 1)));
            expect_store(word_t'('h340 + 4 * (r - 1)), word_t'(37 * r - 100));
        end
        finish_program();
        run_and_check();
    endtask

    task automatic test_reg_zero();
        begin_test("register zero");
        emit(asm_i(op_imm, f3_add, 0, 0, 123));
        emit(asm_s(0, 0, 'h380));
        expect_store(32'h380, '0);
        finish_program();
        run_and_check();
    endtask

    initial begin
        rst_n = 1'b0;
        test_reset_state();
        test_alu_ops();
        test_load_use();
        test_branches();
        test_back_pressure();
        test_reg_zero();
        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compute_unit.f ====
cu_core_pkg.sv
cu_isa_pkg.sv
cu_fetch.sv
cu_decoder.sv
cu_scoreboard.sv
cu_regfile.sv
cu_alu.sv
cu_lsu.sv
cu_top.sv
cu_properties.sv
tb_cu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the compute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cu -f compute_unit.f -o sim_cu \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_cu > sim.log 2>&1
cat sim.log

grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
